// File: include/soc_periph_macros.svh
`ifndef SOC_PERIPH_MACROS_SVH
`define SOC_PERIPH_MACROS_SVH

// Number of 32-bit interrupt sources behind the controller.
`define SOC_NUM_PERIPHS 2

// ----------------------------------------
// Block select codes in address bits 11:10
// ----------------------------------------
`define SOC_BLK_ICTL  2'd0
`define SOC_BLK_TIMER 2'd1
`define SOC_BLK_GPIO  2'd2

// Interrupt controller regions in offset bits 9:8.
`define SOC_ICTL_PEND_REGION 2'd1
`define SOC_ICTL_EN_REGION   2'd2

// ----------------------------------------
// Peripheral register selects
// ----------------------------------------
`define SOC_TMR_COUNT    2'd0
`define SOC_TMR_COMPARE  2'd1
`define SOC_TMR_CTRL     2'd2
`define SOC_GPIO_LEVEL   2'd0
`define SOC_GPIO_RISE_EN 2'd1
`define SOC_GPIO_FALL_EN 2'd2

`endif

// File: rtl/soc_mmio_pkg.sv
package soc_mmio_pkg;

  // Full CPU side address. Bits 11:10 pick the block.
  typedef logic [11:0] mmio_addr_t;

  // Write data, per-bit write mask and read data.
  typedef logic [31:0] mmio_word_t;

  // ----------------------------------------
  // Block offset in address bits 9:0
  // ----------------------------------------
  // The interrupt controller sees the offset as five 2-bit groups.
  // Group 4 is the region and groups 3:0 form the peripheral index.
  // The timer and GPIO blocks see a flat word and only use bits 1:0
  // as the register select. The upper 8 bits are ignored.
  typedef union packed {
    logic [4:0][1:0] ictl; // [4] region, [3:0] index.
    logic [9:0]      regs; // [1:0] register select.
  } mmio_offset_u;

endpackage

// File: rtl/soc_irq_pkg.sv
package soc_irq_pkg;

  // One peripheral's trigger, pending or enable word.
  typedef logic [31:0] irq_word_t;

  // Peripheral index inside a controller region.
  typedef logic [7:0] periph_idx_t;

endpackage

// File: rtl/soc_mmio_decode.sv
`timescale 1ns/1ps

`include "soc_periph_macros.svh"

module soc_mmio_decode (
  input  soc_mmio_pkg::mmio_addr_t   addr,
  input  soc_mmio_pkg::mmio_word_t   wmask,
  input  soc_mmio_pkg::mmio_word_t   ictl_rdata,
  input  soc_mmio_pkg::mmio_word_t   timer_rdata,
  input  soc_mmio_pkg::mmio_word_t   gpio_rdata,
  output soc_mmio_pkg::mmio_offset_u offset,
  output soc_mmio_pkg::mmio_word_t   ictl_wmask,
  output soc_mmio_pkg::mmio_word_t   timer_wmask,
  output soc_mmio_pkg::mmio_word_t   gpio_wmask,
  output soc_mmio_pkg::mmio_word_t   rdata
);

  logic [1:0] blk;

  assign blk    = addr[11:10];
  assign offset = soc_mmio_pkg::mmio_offset_u'(addr[9:0]); // Same offset to every block.

  // ----------------------------------------
  // Write mask steering
  // ----------------------------------------
  assign ictl_wmask  = (blk == `SOC_BLK_ICTL)  ? wmask : '0;
  assign timer_wmask = (blk == `SOC_BLK_TIMER) ? wmask : '0;
  assign gpio_wmask  = (blk == `SOC_BLK_GPIO)  ? wmask : '0;

  // Unmapped block reads zero.
  always_comb begin
    case (blk)
      `SOC_BLK_ICTL:  rdata = ictl_rdata;
      `SOC_BLK_TIMER: rdata = timer_rdata;
      `SOC_BLK_GPIO:  rdata = gpio_rdata;
      default:        rdata = '0;
    endcase
  end

endmodule

// File: rtl/soc_ictl.sv
`timescale 1ns/1ps

`include "soc_periph_macros.svh"

module soc_ictl #(
  parameter int NUM_PERIPHS = `SOC_NUM_PERIPHS
) (
  input  logic                      clkrst_core_clk,
  input  logic                      clkrst_core_rst_n,
  input  soc_mmio_pkg::mmio_offset_u offset,
  input  soc_mmio_pkg::mmio_word_t  wdata,
  input  soc_mmio_pkg::mmio_word_t  wmask,
  input  logic [32*NUM_PERIPHS-1:0] interrupt_trigger,
  output soc_mmio_pkg::mmio_word_t  rdata,
  output logic                      int_pending
);

  soc_irq_pkg::irq_word_t    pending [NUM_PERIPHS];
  soc_irq_pkg::irq_word_t    enable [NUM_PERIPHS];
  soc_irq_pkg::irq_word_t    next_pending [NUM_PERIPHS];
  soc_irq_pkg::irq_word_t    next_enable [NUM_PERIPHS];
  soc_mmio_pkg::mmio_word_t  summary;
  logic [1:0]                region;
  soc_irq_pkg::periph_idx_t  index;

  assign region = offset.ictl[4];
  assign index  = offset.ictl[3:0];

  // One summary bit per peripheral with an enabled pending source.
  always_comb begin
    summary = '0;
    for (int i = 0; i < NUM_PERIPHS; i++) begin
      summary[i] = |(pending[i] & enable[i]);
    end
  end

  assign int_pending = |summary;

  // ----------------------------------------
  // Read back
  // ----------------------------------------
  always_comb begin
    rdata = '0;
    if (offset == '0) begin
      rdata = summary;
    end else if (region == `SOC_ICTL_PEND_REGION) begin
      for (int i = 0; i < NUM_PERIPHS; i++) begin
        if (index == soc_irq_pkg::periph_idx_t'(i)) rdata = pending[i];
      end
    end else if (region == `SOC_ICTL_EN_REGION) begin
      for (int i = 0; i < NUM_PERIPHS; i++) begin
        if (index == soc_irq_pkg::periph_idx_t'(i)) rdata = enable[i];
      end
    end
  end

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_PERIPHS; i++) begin
      next_pending[i] = pending[i];
      next_enable[i]  = enable[i];
      if (index == soc_irq_pkg::periph_idx_t'(i)) begin
        if (region == `SOC_ICTL_PEND_REGION) begin
          next_pending[i] = pending[i] & ~(wdata & wmask); // Write one to clear.
        end else if (region == `SOC_ICTL_EN_REGION) begin
          next_enable[i] = (enable[i] & ~wmask) | (wdata & wmask);
        end
      end
      // New triggers override a clear in the same cycle.
      next_pending[i] = next_pending[i] | interrupt_trigger[32*i +: 32];
    end
  end

  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      for (int i = 0; i < NUM_PERIPHS; i++) begin
        pending[i] <= '0;
        enable[i]  <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_PERIPHS; i++) begin
        pending[i] <= next_pending[i];
        enable[i]  <= next_enable[i];
      end
    end
  end

endmodule

// File: rtl/soc_timer.sv
`timescale 1ns/1ps

`include "soc_periph_macros.svh"

module soc_timer (
  input  logic                       clkrst_core_clk,
  input  logic                       clkrst_core_rst_n,
  input  soc_mmio_pkg::mmio_offset_u offset,
  input  soc_mmio_pkg::mmio_word_t   wdata,
  input  soc_mmio_pkg::mmio_word_t   wmask,
  output soc_mmio_pkg::mmio_word_t   rdata,
  output soc_irq_pkg::irq_word_t     trigger,
  output logic                       match
);

  soc_mmio_pkg::mmio_word_t count;
  soc_mmio_pkg::mmio_word_t compare;
  logic                     enable;
  logic [1:0]               sel;

  assign sel = offset.regs[1:0];

  // Match only counts while the timer runs.
  assign match   = enable && (count == compare);
  assign trigger = {31'b0, match};

  always_comb begin
    case (sel)
      `SOC_TMR_COUNT:   rdata = count;
      `SOC_TMR_COMPARE: rdata = compare;
      `SOC_TMR_CTRL:    rdata = {31'b0, enable};
      default:          rdata = '0;
    endcase
  end

  // ----------------------------------------
  // Counter and registers
  // ----------------------------------------
  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      count   <= '0;
      compare <= '0;
      enable  <= 1'b0;
    end else begin
      if (match) begin
        count <= '0; // Wrap on compare.
      end else if (enable) begin
        count <= count + 32'd1;
      end
      if (sel == `SOC_TMR_COMPARE) begin
        compare <= (compare & ~wmask) | (wdata & wmask);
      end
      if (sel == `SOC_TMR_CTRL && wmask[0]) begin
        enable <= wdata[0];
      end
    end
  end

endmodule

// File: rtl/soc_gpio_irq.sv
`timescale 1ns/1ps

`include "soc_periph_macros.svh"

module soc_gpio_irq (
  input  logic                       clkrst_core_clk,
  input  logic                       clkrst_core_rst_n,
  input  soc_mmio_pkg::mmio_offset_u offset,
  input  soc_mmio_pkg::mmio_word_t   wdata,
  input  soc_mmio_pkg::mmio_word_t   wmask,
  input  logic [31:0]                gpio_in,
  output soc_mmio_pkg::mmio_word_t   rdata,
  output soc_irq_pkg::irq_word_t     trigger
);

  logic [31:0]              sync_q1;
  logic [31:0]              sync_q2;
  logic [31:0]              prev_q;
  soc_mmio_pkg::mmio_word_t rise_en;
  soc_mmio_pkg::mmio_word_t fall_en;
  logic [1:0]               sel;

  assign sel = offset.regs[1:0];

  // Edges are seen between the second sync flop and the previous value.
  assign trigger = (sync_q2 & ~prev_q & rise_en) | (~sync_q2 & prev_q & fall_en);

  always_comb begin
    case (sel)
      `SOC_GPIO_LEVEL:   rdata = sync_q2;
      `SOC_GPIO_RISE_EN: rdata = rise_en;
      `SOC_GPIO_FALL_EN: rdata = fall_en;
      default:           rdata = '0;
    endcase
  end

  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      prev_q  <= '0;
      rise_en <= '0;
      fall_en <= '0;
    end else begin
      sync_q1 <= gpio_in;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
      if (sel == `SOC_GPIO_RISE_EN) rise_en <= (rise_en & ~wmask) | (wdata & wmask);
      if (sel == `SOC_GPIO_FALL_EN) fall_en <= (fall_en & ~wmask) | (wdata & wmask);
    end
  end

endmodule

// File: rtl/soc_periph_top.sv
`timescale 1ns/1ps

`include "soc_periph_macros.svh"

module soc_periph_top (
  input  logic                     clkrst_core_clk,
  input  logic                     clkrst_core_rst_n,
  input  soc_mmio_pkg::mmio_addr_t addr,
  input  soc_mmio_pkg::mmio_word_t wdata,
  input  soc_mmio_pkg::mmio_word_t wmask,
  input  logic [31:0]              gpio_in,
  output soc_mmio_pkg::mmio_word_t rdata,
  output logic                     int_pending,
  output logic                     timer_match
);

  soc_mmio_pkg::mmio_offset_u offset;
  soc_mmio_pkg::mmio_word_t   ictl_wmask;
  soc_mmio_pkg::mmio_word_t   timer_wmask;
  soc_mmio_pkg::mmio_word_t   gpio_wmask;
  soc_mmio_pkg::mmio_word_t   ictl_rdata;
  soc_mmio_pkg::mmio_word_t   timer_rdata;
  soc_mmio_pkg::mmio_word_t   gpio_rdata;
  soc_irq_pkg::irq_word_t     timer_trigger;
  soc_irq_pkg::irq_word_t     gpio_trigger;

  soc_mmio_decode u_decode (
    .addr        (addr),
    .wmask       (wmask),
    .ictl_rdata  (ictl_rdata),
    .timer_rdata (timer_rdata),
    .gpio_rdata  (gpio_rdata),
    .offset      (offset),
    .ictl_wmask  (ictl_wmask),
    .timer_wmask (timer_wmask),
    .gpio_wmask  (gpio_wmask),
    .rdata       (rdata)
  );

  // Peripheral 0 is the timer, peripheral 1 the GPIO block.
  soc_ictl #(
    .NUM_PERIPHS (`SOC_NUM_PERIPHS)
  ) u_ictl (
    .clkrst_core_clk   (clkrst_core_clk),
    .clkrst_core_rst_n (clkrst_core_rst_n),
    .offset            (offset),
    .wdata             (wdata),
    .wmask             (ictl_wmask),
    .interrupt_trigger ({gpio_trigger, timer_trigger}),
    .rdata             (ictl_rdata),
    .int_pending       (int_pending)
  );

  soc_timer u_timer (
    .clkrst_core_clk   (clkrst_core_clk),
    .clkrst_core_rst_n (clkrst_core_rst_n),
    .offset            (offset),
    .wdata             (wdata),
    .wmask             (timer_wmask),
    .rdata             (timer_rdata),
    .trigger           (timer_trigger),
    .match             (timer_match)
  );

  soc_gpio_irq u_gpio (
    .clkrst_core_clk   (clkrst_core_clk),
    .clkrst_core_rst_n (clkrst_core_rst_n),
    .offset            (offset),
    .wdata             (wdata),
    .wmask             (gpio_wmask),
    .gpio_in           (gpio_in),
    .rdata             (gpio_rdata),
    .trigger           (gpio_trigger)
  );

endmodule

// File: sim/tb_soc_periph.sv
`timescale 1ns/1ps

`include "soc_periph_macros.svh"

module tb_soc_periph;

  logic                     clkrst_core_clk;
  logic                     clkrst_core_rst_n;
  soc_mmio_pkg::mmio_addr_t addr;
  soc_mmio_pkg::mmio_word_t wdata;
  soc_mmio_pkg::mmio_word_t wmask;
  logic [31:0]              gpio_in;
  soc_mmio_pkg::mmio_word_t rdata;
  logic                     int_pending;
  logic                     timer_match;

  logic [31:0] lfsr;
  int          test_errs;
  int          total_errs;
  int          tests_run;
  int          tests_failed;
  logic        seen_match;
  logic [31:0] seen_rdata;

  // Reference model state.
  logic [31:0] m_pend [`SOC_NUM_PERIPHS];
  logic [31:0] m_en [`SOC_NUM_PERIPHS];
  logic [31:0] m_cnt;
  logic [31:0] m_cmp;
  logic        m_ten;
  logic [31:0] m_sq1;
  logic [31:0] m_sq2;
  logic [31:0] m_prev;
  logic [31:0] m_rise;
  logic [31:0] m_fall;

  soc_periph_top DUT (
    .clkrst_core_clk   (clkrst_core_clk),
    .clkrst_core_rst_n (clkrst_core_rst_n),
    .addr              (addr),
    .wdata             (wdata),
    .wmask             (wmask),
    .gpio_in           (gpio_in),
    .rdata             (rdata),
    .int_pending       (int_pending),
    .timer_match       (timer_match)
  );

  always #20 clkrst_core_clk = ~clkrst_core_clk;

  // Galois LFSR stepped once per bit taken.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) lfsr = lfsr ^ 32'h8020_0003;
      val[i] = lsb;
    end
    return val;
  endfunction

  function automatic logic [11:0] ictl_addr(input logic [1:0] region, input logic [7:0] idx);
    return {`SOC_BLK_ICTL, region, idx};
  endfunction

  function automatic logic [11:0] reg_addr(input logic [1:0] blk, input logic [1:0] sel);
    return {blk, 8'd0, sel};
  endfunction

  // ----------------------------------------
  // Model
  // ----------------------------------------
  function automatic logic [31:0] masked(input logic [31:0] old, d, m);
    return (old & ~m) | (d & m);
  endfunction

  function automatic logic [31:0] model_summary();
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < `SOC_NUM_PERIPHS; i++) val[i] = |(m_pend[i] & m_en[i]);
    return val;
  endfunction

  function automatic logic model_match();
    return m_ten && (m_cnt == m_cmp);
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] a);
    logic [31:0] val;
    val = '0;
    case (a[11:10])
      `SOC_BLK_ICTL: begin
        if (a[9:0] == '0) begin
          val = model_summary();
        end else if (a[7:0] < `SOC_NUM_PERIPHS) begin
          if (a[9:8] == `SOC_ICTL_PEND_REGION) val = m_pend[a[7:0]];
          else if (a[9:8] == `SOC_ICTL_EN_REGION) val = m_en[a[7:0]];
        end
      end
      `SOC_BLK_TIMER: begin
        if (a[1:0] == `SOC_TMR_COUNT) val = m_cnt;
        else if (a[1:0] == `SOC_TMR_COMPARE) val = m_cmp;
        else if (a[1:0] == `SOC_TMR_CTRL) val = {31'b0, m_ten};
      end
      `SOC_BLK_GPIO: begin
        if (a[1:0] == `SOC_GPIO_LEVEL) val = m_sq2;
        else if (a[1:0] == `SOC_GPIO_RISE_EN) val = m_rise;
        else if (a[1:0] == `SOC_GPIO_FALL_EN) val = m_fall;
      end
      default: val = '0; // Unmapped.
    endcase
    return val;
  endfunction

  // Advance the model by one rising edge with the inputs held this cycle.
  function automatic void model_clock();
    logic [31:0] trig [`SOC_NUM_PERIPHS];
    logic        match;
    match   = model_match();
    trig[0] = {31'b0, match};
    trig[1] = (m_sq2 & ~m_prev & m_rise) | (~m_sq2 & m_prev & m_fall);
    for (int i = 0; i < `SOC_NUM_PERIPHS; i++) begin
      if (addr[11:10] == `SOC_BLK_ICTL && addr[7:0] == i) begin
        if (addr[9:8] == `SOC_ICTL_PEND_REGION) m_pend[i] = m_pend[i] & ~(wdata & wmask);
        if (addr[9:8] == `SOC_ICTL_EN_REGION) m_en[i] = masked(m_en[i], wdata, wmask);
      end
      m_pend[i] = m_pend[i] | trig[i]; // Trigger wins.
    end
    if (match) m_cnt = '0;
    else if (m_ten) m_cnt = m_cnt + 1;
    if (addr[11:10] == `SOC_BLK_TIMER) begin
      if (addr[1:0] == `SOC_TMR_COMPARE) m_cmp = masked(m_cmp, wdata, wmask);
      if (addr[1:0] == `SOC_TMR_CTRL && wmask[0]) m_ten = wdata[0];
    end
    m_prev = m_sq2;
    m_sq2  = m_sq1;
    m_sq1  = gpio_in;
    if (addr[11:10] == `SOC_BLK_GPIO) begin
      if (addr[1:0] == `SOC_GPIO_RISE_EN) m_rise = masked(m_rise, wdata, wmask);
      if (addr[1:0] == `SOC_GPIO_FALL_EN) m_fall = masked(m_fall, wdata, wmask);
    end
  endfunction

  // ----------------------------------------
  // Bus cycles and checks
  // ----------------------------------------
  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("ERR %s expected %h actual %h", name, exp, got);
      test_errs++;
    end
  endtask

  // Outputs are checked mid cycle and the model steps at the edge.
  task automatic run_cycle(input string name);
    @(negedge clkrst_core_clk);
    check_word({name, " rdata"}, model_read(addr), rdata);
    check_word({name, " int_pending"}, {31'b0, model_summary() != 0}, {31'b0, int_pending});
    check_word({name, " timer_match"}, {31'b0, model_match()}, {31'b0, timer_match});
    seen_match = timer_match;
    seen_rdata = rdata;
    @(posedge clkrst_core_clk);
    model_clock();
    #2;
  endtask

  task automatic access(input string name, input logic [11:0] a, input logic [31:0] d, m);
    addr  = a;
    wdata = d;
    wmask = m;
    run_cycle(name);
  endtask

  task automatic wait_match(input string name, output int cycles);
    int n;
    n = 0;
    seen_match = 1'b0;
    while (!seen_match && n < 64) begin
      access(name, reg_addr(`SOC_BLK_TIMER, `SOC_TMR_COUNT), '0, '0);
      n++;
    end
    if (!seen_match) begin
      $display("%s: timer match did not arrive within 64 cycles", name);
      test_errs++;
    end
    cycles = n;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    total_errs += test_errs;
    if (test_errs > 0) tests_failed++;
    $display("%s: done, %0d errors", name, test_errs);
    test_errs = 0;
  endtask

  initial begin
    logic [7:0]  idx;
    logic [31:0] val;
    int          cycles;
    lfsr              = 32'hd121;
    clkrst_core_clk   = 1'b0;
    clkrst_core_rst_n = 1'b0;
    addr              = '0;
    wdata             = '0;
    wmask             = '0;
    gpio_in           = '0;
    test_errs         = 0;
    total_errs        = 0;
    tests_run         = 0;
    tests_failed      = 0;
    for (int i = 0; i < `SOC_NUM_PERIPHS; i++) begin
      m_pend[i] = '0;
      m_en[i]   = '0;
    end
    {m_cnt, m_cmp, m_ten, m_sq1, m_sq2, m_prev, m_rise, m_fall} = '0;
    repeat (10) @(posedge clkrst_core_clk);
    #2;
    clkrst_core_rst_n = 1'b1;

    // Every mapped register is zero after reset.
    access("reset_values", 12'h000, '0, '0);
    check_word("reset_values summary", '0, seen_rdata);
    for (int i = 0; i < `SOC_NUM_PERIPHS; i++) begin
      access("reset_values", ictl_addr(`SOC_ICTL_PEND_REGION, 8'(i)), '0, '0);
      check_word("reset_values pending", '0, seen_rdata);
      access("reset_values", ictl_addr(`SOC_ICTL_EN_REGION, 8'(i)), '0, '0);
      check_word("reset_values enable", '0, seen_rdata);
    end
    for (int s = 0; s < 3; s++) begin
      access("reset_values", reg_addr(`SOC_BLK_TIMER, 2'(s)), '0, '0);
      check_word("reset_values timer", '0, seen_rdata);
      access("reset_values", reg_addr(`SOC_BLK_GPIO, 2'(s)), '0, '0);
      check_word("reset_values gpio", '0, seen_rdata);
    end
    finish_test("reset_values");

    repeat (20) begin
      idx = 8'(rand_bits(1));
      access("enable_writes", ictl_addr(`SOC_ICTL_EN_REGION, idx), rand_bits(32), rand_bits(32));
      access("enable_writes", ictl_addr(`SOC_ICTL_EN_REGION, idx), '0, '0);
      access("enable_writes", {2'b11, 10'(rand_bits(10))}, rand_bits(32), rand_bits(32));
      check_word("enable_writes unmapped", '0, seen_rdata);
    end
    finish_test("enable_writes");

    // ----------------------------------------
    // Edge and timer interrupts
    // ----------------------------------------
    access("gpio_edges", reg_addr(`SOC_BLK_GPIO, `SOC_GPIO_RISE_EN), rand_bits(32), '1);
    access("gpio_edges", reg_addr(`SOC_BLK_GPIO, `SOC_GPIO_FALL_EN), rand_bits(32), '1);
    repeat (40) begin
      if (rand_bits(1)) gpio_in = rand_bits(32);
      if (rand_bits(1)) access("gpio_edges", reg_addr(`SOC_BLK_GPIO, `SOC_GPIO_LEVEL), '0, '0);
      else access("gpio_edges", ictl_addr(`SOC_ICTL_PEND_REGION, 8'd1), '0, '0);
    end
    finish_test("gpio_edges");

    val = 32'd3 + rand_bits(3);
    access("timer_period", reg_addr(`SOC_BLK_TIMER, `SOC_TMR_COMPARE), val, '1);
    access("timer_period", reg_addr(`SOC_BLK_TIMER, `SOC_TMR_CTRL), 32'd1, 32'd1);
    wait_match("timer_period", cycles);
    repeat (3) begin
      wait_match("timer_period", cycles);
      check_word("timer_period interval", val + 32'd1, cycles);
    end
    access("timer_period", ictl_addr(`SOC_ICTL_PEND_REGION, 8'd0), '0, '0);
    check_word("timer_period pending bit 0", 32'd1, {31'b0, seen_rdata[0]});
    finish_test("timer_period");

    // Timer keeps running, so clears race live triggers.
    access("clear_and_level", ictl_addr(`SOC_ICTL_EN_REGION, 8'd0), '1, '1);
    access("clear_and_level", ictl_addr(`SOC_ICTL_EN_REGION, 8'd1), '1, '1);
    repeat (60) begin
      if (rand_bits(1)) gpio_in = rand_bits(32);
      idx = 8'(rand_bits(1));
      case (rand_bits(2))
        32'd1: begin
          access("clear_and_level", ictl_addr(`SOC_ICTL_PEND_REGION, idx),
                 rand_bits(32), rand_bits(32));
        end
        32'd2: access("clear_and_level", ictl_addr(`SOC_ICTL_PEND_REGION, idx), '0, '0);
        default: access("clear_and_level", 12'h000, '0, '0);
      endcase
    end
    finish_test("clear_and_level");

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+include
rtl/soc_mmio_pkg.sv
rtl/soc_irq_pkg.sv
rtl/soc_mmio_decode.sv
rtl/soc_ictl.sv
rtl/soc_timer.sv
rtl/soc_gpio_irq.sv
rtl/soc_periph_top.sv
sim/tb_soc_periph.sv
